//--- build.f
+incdir+logic
logic/board_pkg.sv
logic/play_pkg.sv
logic/step_timer.sv
logic/ship_mover.sv
logic/rock_mover.sv
logic/collision_judge.sv
logic/dodge_game_top.sv
verification/dodge_game_tb.sv

//--- logic/board_pkg.sv
package board_pkg;

    // Lane index across the board
    typedef logic [1:0] lane_t;

    // Row index, row 0 is where the ship sits
    typedef logic [1:0] row_t;

    // One board position
    // Lane is the upper field, so equal cells compare as equal vectors
    typedef struct packed {
        lane_t lane;
        row_t  row;
    } cell_t;

endpackage

//--- logic/collision_judge.sv
`timescale 1ns/1ps

`include "game_defines.svh"

module collision_judge (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   restart,
    input  logic                   passed,
    input  board_pkg::cell_t       ship_cell,
    input  board_pkg::cell_t       rock_cell,
    output logic                   frozen,
    output play_pkg::game_status_t status
);

    play_pkg::game_state_e   state;
    play_pkg::game_state_e   state_next;
    logic [`SCORE_WIDTH-1:0] score;
    logic                    hit;

    assign hit = (ship_cell == rock_cell);

    // Game FSM, CRASHED only leaves through restart
    always_comb begin
        state_next = state;
        case (state)
            play_pkg::PLAYING: begin
                if (hit) begin
                    state_next = play_pkg::CRASHED;
                end
            end
            play_pkg::CRASHED: begin
                state_next = play_pkg::CRASHED;
            end
            default: begin
                state_next = play_pkg::PLAYING;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            state <= play_pkg::PLAYING;
            score <= '0;
        end else begin
            state <= state_next;
            // A dodge counts only if no crash is taken on the same edge
            if (passed && state == play_pkg::PLAYING && !hit && score != '1) begin
                score <= score + 1'b1;
            end
        end
    end

    assign frozen       = (state == play_pkg::CRASHED);
    assign status.state = state;
    assign status.score = score;

endmodule

//--- logic/dodge_game_top.sv
`timescale 1ns/1ps

`include "game_defines.svh"

module dodge_game_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   restart,
    input  play_pkg::buttons_t     buttons,
    output board_pkg::cell_t       ship_cell,
    output board_pkg::cell_t       rock_cell,
    output play_pkg::game_status_t status
);

    logic ship_step;
    logic rock_step;
    logic frozen;
    logic passed;

    // Each mover runs at its own pace
    step_timer #(
        .PERIOD(`SHIP_STEP_CYCLES)
    ) ship_timer (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .step    (ship_step)
    );

    step_timer #(
        .PERIOD(`ROCK_STEP_CYCLES)
    ) rock_timer (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .step    (rock_step)
    );

    ship_mover ship_move (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .step      (ship_step),
        .frozen    (frozen),
        .buttons   (buttons),
        .ship_cell (ship_cell)
    );

    rock_mover rock_move (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .step      (rock_step),
        .frozen    (frozen),
        .rock_cell (rock_cell),
        .passed    (passed)
    );

    // Judge freezes both movers after a crash
    collision_judge judge (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .passed    (passed),
        .ship_cell (ship_cell),
        .rock_cell (rock_cell),
        .frozen    (frozen),
        .status    (status)
    );

endmodule

//--- logic/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Board geometry
`define LANE_COUNT 3
`define ROW_COUNT 4

// Step periods in clk cycles
// Kept short so a full rock lap fits in a short run
`define SHIP_STEP_CYCLES 4
`define ROCK_STEP_CYCLES 16

// Dodge counter width
`define SCORE_WIDTH 8

`endif

//--- logic/play_pkg.sv
package play_pkg;

`include "game_defines.svh"

    // Raw button levels from the player
    typedef struct packed {
        logic up;
        logic down;
    } buttons_t;

    // Decoded ship command
    typedef enum logic [1:0] {
        MOVE_NONE = 2'd0,
        MOVE_UP   = 2'd1,
        MOVE_DOWN = 2'd2
    } move_cmd_e;

    // Game FSM states
    typedef enum logic {
        PLAYING = 1'b0,
        CRASHED = 1'b1
    } game_state_e;

    typedef struct packed {
        game_state_e             state;
        logic [`SCORE_WIDTH-1:0] score;
    } game_status_t;

endpackage

//--- logic/rock_mover.sv
`timescale 1ns/1ps

`include "game_defines.svh"

module rock_mover (
    input  logic              clk,
    input  logic              rst,
    input  logic              restart,
    input  logic              step,
    input  logic              frozen,
    output board_pkg::cell_t  rock_cell,
    output logic              passed
);

    localparam board_pkg::lane_t LAST_LANE = board_pkg::lane_t'(`LANE_COUNT - 1);
    localparam board_pkg::row_t  TOP_ROW   = board_pkg::row_t'(`ROW_COUNT - 1);

    board_pkg::cell_t next_cell;
    logic             at_bottom;

    assign at_bottom = (rock_cell.row == '0);

    // Successor along the fall path
    // Leaving row 0 wraps to the top of the next lane, lane 2 back to lane 0
    always_comb begin
        next_cell = rock_cell;
        if (at_bottom) begin
            next_cell.row = TOP_ROW;
            if (rock_cell.lane == LAST_LANE) begin
                next_cell.lane = '0;
            end else begin
                next_cell.lane = rock_cell.lane + 1'b1;
            end
        end else begin
            next_cell.row = rock_cell.row - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            rock_cell.lane <= '0;
            rock_cell.row  <= TOP_ROW;
            passed         <= 1'b0;
        end else begin
            passed <= 1'b0;
            if (step && !frozen) begin
                rock_cell <= next_cell;
                // Marks the step that took the rock past the ship row
                passed    <= at_bottom;
            end
        end
    end

endmodule

//--- logic/ship_mover.sv
`timescale 1ns/1ps

`include "game_defines.svh"

module ship_mover (
    input  logic                clk,
    input  logic                rst,
    input  logic                restart,
    input  logic                step,
    input  logic                frozen,
    input  play_pkg::buttons_t  buttons,
    output board_pkg::cell_t    ship_cell
);

    localparam board_pkg::lane_t LAST_LANE = board_pkg::lane_t'(`LANE_COUNT - 1);

    play_pkg::move_cmd_e cmd;

    // Down wins when both buttons are held
    always_comb begin
        if (buttons.down) begin
            cmd = play_pkg::MOVE_DOWN;
        end else if (buttons.up) begin
            cmd = play_pkg::MOVE_UP;
        end else begin
            cmd = play_pkg::MOVE_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            ship_cell.lane <= '0;
            ship_cell.row  <= '0;
        end else if (step && !frozen) begin
            // Lane clamps at both board edges
            case (cmd)
                play_pkg::MOVE_DOWN: begin
                    if (ship_cell.lane != LAST_LANE) begin
                        ship_cell.lane <= ship_cell.lane + 1'b1;
                    end
                end
                play_pkg::MOVE_UP: begin
                    if (ship_cell.lane != '0) begin
                        ship_cell.lane <= ship_cell.lane - 1'b1;
                    end
                end
                default: begin
                    ship_cell.lane <= ship_cell.lane;
                end
            endcase
            ship_cell.row <= '0;
        end
    end

endmodule

//--- logic/step_timer.sv
`timescale 1ns/1ps

module step_timer #(
    parameter int PERIOD = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic step
);

    localparam int CW = (PERIOD > 2) ? $clog2(PERIOD) : 1;

    logic [CW-1:0] count;
    logic          wrap;

    assign wrap = (count == CW'(PERIOD - 1));

    // Free-running counter, step is registered on the wrap
    // so the first pulse lands PERIOD cycles after release
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            count <= '0;
            step  <= 1'b0;
        end else begin
            step <= wrap;
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash

# Build and run the dodge game testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=dodge_game_sim
LOG_FILE=sim.log

if ! verilator --binary --timing --timescale 1ns/1ps \
        -f build.f --top-module dodge_game_tb \
        -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '** PASS **' "$LOG_FILE"; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found in $LOG_FILE"
exit 1

//--- verification/dodge_game_tb.sv
`timescale 1ns/1ps

`include "game_defines.svh"

module dodge_game_tb;

    localparam int SHIP_STEP  = `SHIP_STEP_CYCLES;
    localparam int ROCK_STEP  = `ROCK_STEP_CYCLES;
    localparam int LAST_LANE  = `LANE_COUNT - 1;
    localparam int TOP_ROW    = `ROW_COUNT - 1;
    localparam int PATH_MOVES = 12;

    // Cycle budget per test
    localparam int RESET_LEN   = 16;
    localparam int CLAMP_LEN   = 16 * SHIP_STEP;
    localparam int PATH_LEN    = 2 * PATH_MOVES * ROCK_STEP;
    localparam int CRASH_LEN   = (2 * `ROW_COUNT + 3) * ROCK_STEP;
    localparam int RESTART_LEN = 4 * ROCK_STEP;
    // Run limit at twice the total budget
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_LEN + CLAMP_LEN + PATH_LEN + CRASH_LEN + RESTART_LEN);

    logic                   clk;
    logic                   rst;
    logic                   restart;
    play_pkg::buttons_t     buttons;
    board_pkg::cell_t       ship_cell;
    board_pkg::cell_t       rock_cell;
    play_pkg::game_status_t status;
    integer                 seed;
    int                     cycle_count = 0;

    dodge_game_top uut (
        .clk       (clk),
        .rst       (rst),
        .restart   (restart),
        .buttons   (buttons),
        .ship_cell (ship_cell),
        .rock_cell (rock_cell),
        .status    (status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic board_pkg::cell_t make_cell(input int lane, input int row);
        board_pkg::cell_t c;
        c.lane = board_pkg::lane_t'(lane);
        c.row  = board_pkg::row_t'(row);
        return c;
    endfunction

    function automatic play_pkg::buttons_t button_levels(input logic up, input logic down);
        play_pkg::buttons_t b;
        b.up   = up;
        b.down = down;
        return b;
    endfunction

    // Fall path goes one row down or from row 0 to the top of the next lane
    function automatic board_pkg::cell_t next_rock_cell(input board_pkg::cell_t c);
        board_pkg::cell_t n;
        if (c.row == 2'd0) begin
            n.lane = board_pkg::lane_t'((int'(c.lane) + 1) % `LANE_COUNT);
            n.row  = board_pkg::row_t'(TOP_ROW);
        end else begin
            n.lane = c.lane;
            n.row  = c.row - 2'd1;
        end
        return n;
    endfunction

    // Step out of the rock's lane into a neighbour
    function automatic play_pkg::buttons_t avoid_rock(input board_pkg::cell_t ship,
                                                      input board_pkg::cell_t rock);
        play_pkg::buttons_t b;
        b = '0;
        if (ship.lane == rock.lane) begin
            if (int'(ship.lane) == LAST_LANE) begin
                b.up = 1'b1;
            end else begin
                b.down = 1'b1;
            end
        end
        return b;
    endfunction

    function automatic play_pkg::buttons_t chase_rock(input board_pkg::cell_t ship,
                                                      input board_pkg::cell_t rock);
        play_pkg::buttons_t b;
        b = '0;
        if (ship.lane < rock.lane) begin
            b.down = 1'b1;
        end else if (ship.lane > rock.lane) begin
            b.up = 1'b1;
        end
        return b;
    endfunction

    task automatic pulse_restart();
        @(posedge clk);
        restart <= 1'b1;
        buttons <= '0;
        @(posedge clk);
        restart <= 1'b0;
    endtask

    task automatic check_reset_values();
        check_value("ship_cell", 32'(ship_cell), 32'(make_cell(0, 0)));
        check_value("rock_cell", 32'(rock_cell), 32'(make_cell(0, TOP_ROW)));
        check_value("status.state", 32'(status.state), 32'(play_pkg::PLAYING));
        check_value("status.score", 32'(status.score), 32'd0);
    endtask

    // Lane may only stay put until it reaches the target
    task automatic wait_ship_lane(input int lane);
        int               waited;
        board_pkg::lane_t start;
        waited = 0;
        @(negedge clk);
        start = ship_cell.lane;
        while (int'(ship_cell.lane) != lane) begin
            check_value("ship_cell.lane", 32'(ship_cell.lane), 32'(start));
            waited++;
            if (waited > 2 * SHIP_STEP) begin
                $display("ship did not reach lane %0d in time", lane);
                abort_run();
            end
            @(negedge clk);
        end
        check_value("ship_cell.row", 32'(ship_cell.row), 32'd0);
    endtask

    task automatic hold_ship_lane(input int lane, input int steps);
        repeat (steps * SHIP_STEP) begin
            @(negedge clk);
            check_value("ship_cell", 32'(ship_cell), 32'(make_cell(lane, 0)));
        end
    endtask

    task automatic expect_reset_state();
        @(negedge clk);
        check_reset_values();
    endtask

    task automatic clamp_ship_at_edges();
        int hold_down;
        int hold_up;
        hold_down = 1 + int'($unsigned($random(seed)) % 2);
        hold_up   = 1 + int'($unsigned($random(seed)) % 2);
        pulse_restart();
        @(posedge clk);
        buttons <= button_levels(1'b0, 1'b1);
        wait_ship_lane(1);
        wait_ship_lane(LAST_LANE);
        hold_ship_lane(LAST_LANE, hold_down);
        @(posedge clk);
        buttons <= button_levels(1'b1, 1'b0);
        wait_ship_lane(1);
        wait_ship_lane(0);
        hold_ship_lane(0, hold_up);
        // Restart from lane 1 so the ship has to return to lane 0
        @(posedge clk);
        buttons <= button_levels(1'b0, 1'b1);
        wait_ship_lane(1);
        pulse_restart();
        @(negedge clk);
        check_reset_values();
    endtask

    task automatic dodge_along_rock_path();
        board_pkg::cell_t prev;
        board_pkg::cell_t ship_now;
        board_pkg::cell_t rock_now;
        int               moves;
        int               waited;
        int               dodges;
        moves  = 0;
        waited = 0;
        dodges = 0;
        pulse_restart();
        @(negedge clk);
        prev = rock_cell;
        while (moves < PATH_MOVES) begin
            ship_now = ship_cell;
            rock_now = rock_cell;
            check_value("status.state", 32'(status.state), 32'(play_pkg::PLAYING));
            if (rock_now != prev) begin
                check_value("rock_cell", 32'(rock_now), 32'(next_rock_cell(prev)));
                check_value("status.score", 32'(status.score), 32'(dodges));
                if (prev.row == 2'd0) begin
                    dodges++;
                end
                prev   = rock_now;
                waited = 0;
                moves++;
            end else begin
                waited++;
                if (waited > 2 * ROCK_STEP) begin
                    $display("rock stopped moving after %0d moves", moves);
                    abort_run();
                end
            end
            @(posedge clk);
            buttons <= avoid_rock(ship_now, rock_now);
            @(negedge clk);
        end
        @(posedge clk);
        buttons <= '0;
        repeat (2) @(negedge clk);
        check_value("status.score", 32'(status.score), 32'(dodges));
    endtask

    task automatic crash_and_freeze();
        board_pkg::cell_t        ship_hold;
        board_pkg::cell_t        rock_hold;
        logic [`SCORE_WIDTH-1:0] score_hold;
        int                      waited;
        waited = 0;
        @(negedge clk);
        while (status.state != play_pkg::CRASHED) begin
            ship_hold = ship_cell;
            rock_hold = rock_cell;
            waited++;
            if (waited > CRASH_LEN) begin
                $display("no crash with the ship parked in the rock lane");
                abort_run();
            end
            @(posedge clk);
            buttons <= chase_rock(ship_hold, rock_hold);
            @(negedge clk);
        end
        check_value("rock_cell.row", 32'(rock_cell.row), 32'd0);
        check_value("rock_cell", 32'(rock_cell), 32'(ship_cell));
        ship_hold  = ship_cell;
        rock_hold  = rock_cell;
        score_hold = status.score;
        // Buttons held while frozen must not move the ship
        @(posedge clk);
        buttons <= button_levels(1'b0, 1'b1);
        repeat (3 * ROCK_STEP) begin
            @(negedge clk);
            check_value("ship_cell", 32'(ship_cell), 32'(ship_hold));
            check_value("rock_cell", 32'(rock_cell), 32'(rock_hold));
            check_value("status.score", 32'(status.score), 32'(score_hold));
            check_value("status.state", 32'(status.state), 32'(play_pkg::CRASHED));
        end
    endtask

    task automatic restart_after_crash();
        int waited;
        waited = 0;
        pulse_restart();
        @(negedge clk);
        check_reset_values();
        while (rock_cell == make_cell(0, TOP_ROW)) begin
            waited++;
            if (waited > 2 * ROCK_STEP) begin
                $display("rock did not resume its path after restart");
                abort_run();
            end
            @(negedge clk);
        end
        check_value("rock_cell", 32'(rock_cell), 32'(next_rock_cell(make_cell(0, TOP_ROW))));
        check_value("status.state", 32'(status.state), 32'(play_pkg::PLAYING));
    endtask

    initial begin
        seed = 32'h42f0;
        rst     <= 1'b1;
        restart <= 1'b0;
        buttons <= '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        expect_reset_state();
        clamp_ship_at_edges();
        dodge_along_rock_path();
        crash_and_freeze();
        restart_after_crash();
        $display("** PASS **");
        $finish;
    end

endmodule
